// ==== logic/mem_stage_pkg.sv ====
/*
 * shared definitions for the memory stage
 *   data/address width, register id width, local space size
 *   dram prefix for instruction misses
 *   operation and access size enums
 *   decode, load info and remote request structs
 */

package mem_stage_pkg;

  localparam int data_width_gp       = 32;
  localparam int reg_addr_width_gp   = 5;
  localparam int local_space_bits_gp = 12;

  // or-ed into an instruction miss address
  localparam logic [data_width_gp-1:0] dram_prefix_gp = 32'h8000_0000;

  typedef enum logic [2:0] {
    op_none     = 3'd0,
    op_load     = 3'd1,
    op_store    = 3'd2,
    op_lr       = 3'd3,
    op_amo_swap = 3'd4,
    op_amo_add  = 3'd5
  } mem_op_e;

  typedef enum logic [1:0] {
    size_byte = 2'd0,
    size_half = 2'd1,
    size_word = 2'd2
  } mem_size_e;

  typedef struct packed {
    mem_op_e   op;
    mem_size_e size;
    logic      is_unsigned;
  } decode_s;

  // travels with a load so the response can be aligned
  typedef struct packed {
    logic      icache_fetch;
    logic      is_unsigned;
    mem_size_e size;
    logic [1:0] part_sel;
  } load_info_s;

  typedef struct packed {
    mem_op_e                    op;
    logic [3:0]                 mask;
    load_info_s                 load_info;
    logic [reg_addr_width_gp-1:0] reg_id;
    logic [data_width_gp-1:0]   data;
    logic [data_width_gp-1:0]   addr;
  } remote_req_s;

endpackage

// ==== logic/lsu.sv ====
/*
 * load store unit
 *   effective and miss address generation
 *   store data replication and byte mask
 *   local dmem / remote network routing
 *   address space checks for atomics and load-reserved
 */

module lsu #(
  parameter int dmem_words_p = 1024
) (
  input  logic                                          clk_i,
  input  logic                                          reset_i,
  input  logic                                          exe_v_i,
  input  mem_stage_pkg::decode_s                        exe_decode_i,
  input  logic [mem_stage_pkg::data_width_gp-1:0]       exe_rs1_i,
  input  logic [mem_stage_pkg::data_width_gp-1:0]       exe_rs2_i,
  input  logic [mem_stage_pkg::data_width_gp-1:0]       exe_offset_i,
  input  logic [mem_stage_pkg::reg_addr_width_gp-1:0]   exe_rd_i,
  input  logic                                          icache_miss_i,
  input  logic [mem_stage_pkg::data_width_gp-1:0]       pc_plus4_i,
  input  logic                                          fifo_full_i,
  output logic                                          exe_ready_o,
  output logic                                          dmem_v_o,
  output logic                                          dmem_w_o,
  output logic [$clog2(dmem_words_p)-1:0]               dmem_addr_o,
  output logic [mem_stage_pkg::data_width_gp-1:0]       dmem_data_o,
  output logic [3:0]                                    dmem_mask_o,
  output logic                                          reserve_o,
  output mem_stage_pkg::load_info_s                     load_tag_o,
  output logic [mem_stage_pkg::reg_addr_width_gp-1:0]   load_rd_o,
  output logic                                          req_v_o,
  output mem_stage_pkg::remote_req_s                    req_o
);

  import mem_stage_pkg::*;

  logic [data_width_gp-1:0] mem_addr;
  logic [data_width_gp-1:0] miss_addr;
  logic [data_width_gp-1:0] store_data;
  logic [3:0]               store_mask;
  logic                     is_local;
  logic                     is_amo;
  logic                     local_op;
  logic                     remote_op;
  load_info_s               load_info;

  assign mem_addr  = exe_rs1_i + exe_offset_i;
  assign miss_addr = (pc_plus4_i - 32'd4) | dram_prefix_gp;

  // local space is the low 4KB, everything above goes to the network
  assign is_local = (mem_addr[data_width_gp-1:local_space_bits_gp] == '0);
  assign is_amo   = exe_decode_i.op inside {op_amo_swap, op_amo_add};

  always_comb begin
    case (exe_decode_i.size)
      size_byte: begin
        store_data = {4{exe_rs2_i[7:0]}};
        store_mask = 4'b0001 << mem_addr[1:0];
      end
      size_half: begin
        store_data = {2{exe_rs2_i[15:0]}};
        store_mask = mem_addr[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        // words and atomics
        store_data = exe_rs2_i;
        store_mask = 4'b1111;
      end
    endcase
  end

  assign local_op  = ~icache_miss_i & is_local
                   & (exe_decode_i.op inside {op_load, op_store, op_lr});
  assign remote_op = icache_miss_i
                   | (~is_local & (is_amo | (exe_decode_i.op inside {op_load, op_store})));

  // stall only when this item needs the queue and it has no room
  assign exe_ready_o = ~(remote_op & fifo_full_i);

  assign dmem_v_o    = exe_v_i & exe_ready_o & local_op;
  assign dmem_w_o    = (exe_decode_i.op == op_store);
  assign dmem_addr_o = mem_addr[2+:$clog2(dmem_words_p)];
  assign dmem_data_o = store_data;
  assign dmem_mask_o = store_mask;
  assign reserve_o   = dmem_v_o & (exe_decode_i.op == op_lr);

  always_comb begin
    load_info.icache_fetch = icache_miss_i;
    load_info.is_unsigned  = icache_miss_i ? 1'b0 : exe_decode_i.is_unsigned;
    load_info.size         = icache_miss_i ? size_word : exe_decode_i.size;
    load_info.part_sel     = icache_miss_i ? 2'b00 : mem_addr[1:0];
  end

  assign load_tag_o = load_info;
  assign load_rd_o  = exe_rd_i;

  // instruction miss goes out as a plain word read
  assign req_v_o = exe_v_i & exe_ready_o & remote_op;
  always_comb begin
    req_o.op        = icache_miss_i ? op_load : exe_decode_i.op;
    req_o.mask      = icache_miss_i ? 4'b1111 : store_mask;
    req_o.load_info = load_info;
    req_o.reg_id    = exe_rd_i;
    req_o.data      = store_data;
    req_o.addr      = icache_miss_i ? miss_addr : mem_addr;
  end

  // atomics are served by the remote side only
  amo_not_local: assert property (@(posedge clk_i) disable iff (!reset_i)
    (exe_v_i && !icache_miss_i && is_amo) |-> !is_local);

  // reservation lives in local dmem
  lr_is_local: assert property (@(posedge clk_i) disable iff (!reset_i)
    (exe_v_i && !icache_miss_i && exe_decode_i.op == op_lr) |-> is_local);

endmodule

// ==== logic/dmem.sv ====
/*
 * local data memory
 *   byte-masked word writes
 *   registered one-cycle read
 *   single-word load-reserved reservation
 */

module dmem #(
  parameter int dmem_words_p = 1024
) (
  input  logic                                    clk_i,
  input  logic                                    reset_i,
  input  logic                                    v_i,
  input  logic                                    w_i,
  input  logic [$clog2(dmem_words_p)-1:0]         addr_i,
  input  logic [mem_stage_pkg::data_width_gp-1:0] data_i,
  input  logic [3:0]                              mask_i,
  input  logic                                    reserve_i,
  output logic [mem_stage_pkg::data_width_gp-1:0] data_o,
  output logic                                    reserve_v_o
);

  import mem_stage_pkg::*;

  logic [data_width_gp-1:0]        mem_r [dmem_words_p];
  logic [$clog2(dmem_words_p)-1:0] reserve_addr_r;
  logic                            reserve_v_r;

  always_ff @(posedge clk_i) begin
    if (v_i & w_i) begin
      for (int i = 0; i < 4; i++) begin
        if (mask_i[i]) begin
          mem_r[addr_i][8*i+:8] <= data_i[8*i+:8];
        end
      end
    end
    if (v_i & ~w_i) begin
      data_o <= mem_r[addr_i];
    end
  end

  // any store that hits the reserved word breaks the reservation
  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      reserve_v_r <= 1'b0;
    end else if (v_i & reserve_i) begin
      reserve_v_r <= 1'b1;
    end else if (v_i & w_i & (addr_i == reserve_addr_r)) begin
      reserve_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (v_i & reserve_i) begin
      reserve_addr_r <= addr_i;
    end
  end

  assign reserve_v_o = reserve_v_r;

endmodule

// ==== logic/load_align.sv ====
/*
 * local load alignment
 *   tag and rd registered beside the memory read
 *   byte/half/word select and sign or zero extension
 */

module load_align (
  input  logic                                        clk_i,
  input  logic                                        reset_i,
  input  logic                                        v_i,
  input  mem_stage_pkg::load_info_s                   tag_i,
  input  logic [mem_stage_pkg::reg_addr_width_gp-1:0] rd_i,
  input  logic [mem_stage_pkg::data_width_gp-1:0]     word_i,
  output logic                                        load_v_o,
  output logic [mem_stage_pkg::data_width_gp-1:0]     load_data_o,
  output logic [mem_stage_pkg::reg_addr_width_gp-1:0] load_rd_o
);

  import mem_stage_pkg::*;

  logic                         v_r;
  load_info_s                   tag_r;
  logic [reg_addr_width_gp-1:0] rd_r;
  logic [data_width_gp-1:0]     shifted;
  logic                         sign_bit;

  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      v_r <= 1'b0;
    end else begin
      v_r <= v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (v_i) begin
      tag_r <= tag_i;
      rd_r  <= rd_i;
    end
  end

  // bring the addressed byte or half down to bit 0
  assign shifted = word_i >> {tag_r.part_sel, 3'b000};

  always_comb begin
    sign_bit = 1'b0;
    case (tag_r.size)
      size_byte: begin
        sign_bit    = ~tag_r.is_unsigned & shifted[7];
        load_data_o = {{24{sign_bit}}, shifted[7:0]};
      end
      size_half: begin
        sign_bit    = ~tag_r.is_unsigned & shifted[15];
        load_data_o = {{16{sign_bit}}, shifted[15:0]};
      end
      default: load_data_o = word_i;
    endcase
  end

  assign load_v_o  = v_r;
  assign load_rd_o = rd_r;

endmodule

// ==== logic/remote_req_fifo.sv ====
/*
 * remote request queue
 *   circular buffer with read/write pointers and count
 *   push and pop in one cycle allowed when full
 */

module remote_req_fifo #(
  parameter int fifo_depth_p = 2
) (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       push_v_i,
  input  mem_stage_pkg::remote_req_s push_i,
  output logic                       full_o,
  output logic                       pop_v_o,
  output mem_stage_pkg::remote_req_s pop_o,
  input  logic                       pop_ready_i
);

  import mem_stage_pkg::*;

  localparam int ptr_width_lp   = $clog2(fifo_depth_p);
  localparam int count_width_lp = $clog2(fifo_depth_p + 1);

  remote_req_s               mem_r [fifo_depth_p];
  logic [ptr_width_lp-1:0]   rd_ptr_r;
  logic [ptr_width_lp-1:0]   wr_ptr_r;
  logic [count_width_lp-1:0] count_r;
  logic                      pop;

  assign pop     = pop_v_o & pop_ready_i;
  assign pop_v_o = (count_r != '0);
  assign pop_o   = mem_r[rd_ptr_r];
  // a full queue still takes a push when the head leaves this cycle
  assign full_o  = (count_r == count_width_lp'(fifo_depth_p)) & ~pop_ready_i;

  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      rd_ptr_r <= '0;
      wr_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (push_v_i) begin
        wr_ptr_r <= (wr_ptr_r == ptr_width_lp'(fifo_depth_p - 1)) ? '0 : wr_ptr_r + 1'b1;
      end
      if (pop) begin
        rd_ptr_r <= (rd_ptr_r == ptr_width_lp'(fifo_depth_p - 1)) ? '0 : rd_ptr_r + 1'b1;
      end
      count_r <= count_r + count_width_lp'(push_v_i) - count_width_lp'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_v_i) begin
      mem_r[wr_ptr_r] <= push_i;
    end
  end

  // the lsu must hold off pushes on a full queue
  no_push_full: assert property (@(posedge clk_i) disable iff (!reset_i)
    push_v_i |-> !full_o);

  // an empty queue has its pointers together
  no_pop_empty: assert property (@(posedge clk_i) disable iff (!reset_i)
    (count_r == '0) |-> (rd_ptr_r == wr_ptr_r));

endmodule

// ==== logic/mem_stage.sv ====
/*
 * memory stage top level
 *   lsu, local dmem, load alignment and remote request queue
 */

module mem_stage #(
  parameter int dmem_words_p = 1024,
  parameter int fifo_depth_p = 2
) (
  input  logic                                        clk_i,
  input  logic                                        reset_i,
  input  logic                                        exe_v_i,
  input  mem_stage_pkg::decode_s                      exe_decode_i,
  input  logic [mem_stage_pkg::data_width_gp-1:0]     exe_rs1_i,
  input  logic [mem_stage_pkg::data_width_gp-1:0]     exe_rs2_i,
  input  logic [mem_stage_pkg::data_width_gp-1:0]     exe_offset_i,
  input  logic [mem_stage_pkg::reg_addr_width_gp-1:0] exe_rd_i,
  input  logic                                        icache_miss_i,
  input  logic [mem_stage_pkg::data_width_gp-1:0]     pc_plus4_i,
  input  logic                                        net_ready_i,
  output logic                                        exe_ready_o,
  output logic                                        load_v_o,
  output logic [mem_stage_pkg::data_width_gp-1:0]     load_data_o,
  output logic [mem_stage_pkg::reg_addr_width_gp-1:0] load_rd_o,
  output logic                                        reserve_v_o,
  output logic                                        net_v_o,
  output mem_stage_pkg::remote_req_s                  net_req_o
);

  import mem_stage_pkg::*;

  logic                            dmem_v;
  logic                            dmem_w;
  logic [$clog2(dmem_words_p)-1:0] dmem_addr;
  logic [data_width_gp-1:0]        dmem_data;
  logic [3:0]                      dmem_mask;
  logic                            reserve;
  logic [data_width_gp-1:0]        dmem_rdata;
  load_info_s                      load_tag;
  logic [reg_addr_width_gp-1:0]    tag_rd;
  logic                            req_v;
  remote_req_s                     req;
  logic                            fifo_full;

  lsu #(.dmem_words_p(dmem_words_p)) lsu0 (
    .clk_i, .reset_i, .exe_v_i, .exe_decode_i, .exe_rs1_i, .exe_rs2_i,
    .exe_offset_i, .exe_rd_i, .icache_miss_i, .pc_plus4_i,
    .fifo_full_i(fifo_full), .exe_ready_o,
    .dmem_v_o(dmem_v), .dmem_w_o(dmem_w), .dmem_addr_o(dmem_addr),
    .dmem_data_o(dmem_data), .dmem_mask_o(dmem_mask), .reserve_o(reserve),
    .load_tag_o(load_tag), .load_rd_o(tag_rd), .req_v_o(req_v), .req_o(req)
  );

  dmem #(.dmem_words_p(dmem_words_p)) dmem0 (
    .clk_i, .reset_i, .v_i(dmem_v), .w_i(dmem_w), .addr_i(dmem_addr),
    .data_i(dmem_data), .mask_i(dmem_mask), .reserve_i(reserve),
    .data_o(dmem_rdata), .reserve_v_o
  );

  // only reads produce a result
  load_align align0 (
    .clk_i, .reset_i, .v_i(dmem_v & ~dmem_w), .tag_i(load_tag), .rd_i(tag_rd),
    .word_i(dmem_rdata), .load_v_o, .load_data_o, .load_rd_o
  );

  remote_req_fifo #(.fifo_depth_p(fifo_depth_p)) fifo0 (
    .clk_i, .reset_i, .push_v_i(req_v), .push_i(req), .full_o(fifo_full),
    .pop_v_o(net_v_o), .pop_o(net_req_o), .pop_ready_i(net_ready_i)
  );

endmodule

// ==== sim/mem_stage_tb_table.svh ====
/*
 * stimulus table for the memory stage testbench
 *   local stores and loads of every size and offset
 *   remote loads, stores, atomics and an instruction miss
 *   back-pressure and reservation sequences
 */

// columns: op, size, unsigned, icache miss, rs1 (pc+4 on a miss), offset, rd,
// net_ready mode (0 low, 1 high, 2 random), probe, expected reserve_v_o
localparam int num_rows_lp = 46;

localparam row_s table_rows [num_rows_lp] = '{
  '{op_store, size_word, 1'b0, 1'b0, 32'h0000_0100, 32'h0000_0000, 5'd1, 2'd1, 1'b0, 1'b0},
  '{op_store, size_word, 1'b0, 1'b0, 32'h0000_0108, 32'hffff_fffc, 5'd2, 2'd1, 1'b0, 1'b0},
  '{op_load, size_word, 1'b0, 1'b0, 32'h0000_0100, 32'h0000_0000, 5'd3, 2'd1, 1'b0, 1'b0},
  '{op_load, size_byte, 1'b0, 1'b0, 32'h0000_0100, 32'h0000_0001, 5'd4, 2'd1, 1'b0, 1'b0},
  '{op_store, size_half, 1'b0, 1'b0, 32'h0000_0100, 32'h0000_0002, 5'd5, 2'd1, 1'b0, 1'b0},
  '{op_load, size_half, 1'b0, 1'b0, 32'h0000_0100, 32'h0000_0002, 5'd6, 2'd1, 1'b0, 1'b0},
  '{op_load, size_half, 1'b1, 1'b0, 32'h0000_0100, 32'h0000_0002, 5'd7, 2'd1, 1'b0, 1'b0},
  '{op_load, size_half, 1'b0, 1'b0, 32'h0000_0100, 32'h0000_0000, 5'd8, 2'd1, 1'b0, 1'b0},
  '{op_store, size_half, 1'b0, 1'b0, 32'h0000_0100, 32'h0000_0000, 5'd9, 2'd1, 1'b0, 1'b0},
  '{op_load, size_word, 1'b0, 1'b0, 32'h0000_0100, 32'h0000_0000, 5'd10, 2'd1, 1'b0, 1'b0},
  '{op_store, size_byte, 1'b0, 1'b0, 32'h0000_0100, 32'h0000_0000, 5'd11, 2'd1, 1'b0, 1'b0},
  '{op_store, size_byte, 1'b0, 1'b0, 32'h0000_0104, 32'hffff_fffd, 5'd12, 2'd1, 1'b0, 1'b0},
  '{op_store, size_byte, 1'b0, 1'b0, 32'h0000_0100, 32'h0000_0002, 5'd13, 2'd1, 1'b0, 1'b0},
  '{op_store, size_byte, 1'b0, 1'b0, 32'h0000_0100, 32'h0000_0003, 5'd14, 2'd1, 1'b0, 1'b0},
  '{op_load, size_byte, 1'b0, 1'b0, 32'h0000_0100, 32'h0000_0000, 5'd15, 2'd1, 1'b0, 1'b0},
  '{op_load, size_byte, 1'b1, 1'b0, 32'h0000_0100, 32'h0000_0001, 5'd16, 2'd1, 1'b0, 1'b0},
  '{op_load, size_byte, 1'b0, 1'b0, 32'h0000_0100, 32'h0000_0002, 5'd17, 2'd1, 1'b0, 1'b0},
  '{op_load, size_byte, 1'b1, 1'b0, 32'h0000_0100, 32'h0000_0003, 5'd18, 2'd1, 1'b0, 1'b0},
  '{op_load, size_half, 1'b1, 1'b0, 32'h0000_0100, 32'h0000_0000, 5'd19, 2'd1, 1'b0, 1'b0},
  // other signedness at every byte and half offset
  '{op_load, size_byte, 1'b1, 1'b0, 32'h0000_0100, 32'h0000_0000, 5'd29, 2'd1, 1'b0, 1'b0},
  '{op_load, size_byte, 1'b0, 1'b0, 32'h0000_0100, 32'h0000_0001, 5'd30, 2'd1, 1'b0, 1'b0},
  '{op_load, size_byte, 1'b1, 1'b0, 32'h0000_0100, 32'h0000_0002, 5'd31, 2'd1, 1'b0, 1'b0},
  '{op_load, size_byte, 1'b0, 1'b0, 32'h0000_0100, 32'h0000_0003, 5'd1, 2'd1, 1'b0, 1'b0},
  '{op_load, size_half, 1'b0, 1'b0, 32'h0000_0100, 32'h0000_0000, 5'd2, 2'd1, 1'b0, 1'b0},
  '{op_load, size_half, 1'b0, 1'b0, 32'h0000_0100, 32'h0000_0002, 5'd3, 2'd1, 1'b0, 1'b0},
  '{op_load, size_half, 1'b1, 1'b0, 32'h0000_0100, 32'h0000_0002, 5'd4, 2'd1, 1'b0, 1'b0},
  '{op_load, size_word, 1'b0, 1'b0, 32'h0000_0100, 32'h0000_0000, 5'd20, 2'd2, 1'b0, 1'b0},
  // remote traffic with random stalls
  '{op_store, size_byte, 1'b0, 1'b0, 32'h0001_0000, 32'h0000_0005, 5'd12, 2'd2, 1'b0, 1'b0},
  '{op_store, size_half, 1'b0, 1'b0, 32'h0001_0000, 32'h0000_0006, 5'd13, 2'd2, 1'b0, 1'b0},
  '{op_load, size_half, 1'b1, 1'b0, 32'h0001_0000, 32'h0000_0002, 5'd14, 2'd2, 1'b0, 1'b0},
  '{op_load, size_byte, 1'b0, 1'b0, 32'h0001_0000, 32'h0000_0003, 5'd15, 2'd2, 1'b0, 1'b0},
  '{op_amo_swap, size_word, 1'b0, 1'b0, 32'h0001_0000, 32'h0000_0008, 5'd16, 2'd2, 1'b0, 1'b0},
  '{op_amo_add, size_word, 1'b0, 1'b0, 32'h0001_0000, 32'h0000_000c, 5'd17, 2'd2, 1'b0, 1'b0},
  '{op_store, size_word, 1'b0, 1'b0, 32'h0004_0000, 32'h0000_0010, 5'd18, 2'd2, 1'b0, 1'b0},
  // a miss ignores its decode fields
  '{op_store, size_byte, 1'b1, 1'b1, 32'h0000_2004, 32'h0000_0001, 5'd19, 2'd2, 1'b0, 1'b0},
  '{op_none, size_word, 1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000, 5'd0, 2'd1, 1'b0, 1'b0},
  // fill the queue, then a remote probe and a local load
  '{op_store, size_word, 1'b0, 1'b0, 32'h0002_0000, 32'h0000_0000, 5'd20, 2'd0, 1'b0, 1'b0},
  '{op_load, size_word, 1'b0, 1'b0, 32'h0002_0000, 32'h0000_0004, 5'd21, 2'd0, 1'b0, 1'b0},
  '{op_amo_add, size_word, 1'b0, 1'b0, 32'h0002_0000, 32'h0000_0008, 5'd22, 2'd0, 1'b1, 1'b0},
  '{op_load, size_word, 1'b0, 1'b0, 32'h0000_0104, 32'h0000_0000, 5'd23, 2'd0, 1'b0, 1'b0},
  '{op_none, size_word, 1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000, 5'd0, 2'd1, 1'b0, 1'b0},
  // reservation set, kept, then broken
  '{op_lr, size_word, 1'b0, 1'b0, 32'h0000_0104, 32'h0000_0000, 5'd24, 2'd1, 1'b0, 1'b1},
  '{op_store, size_word, 1'b0, 1'b0, 32'h0000_0108, 32'h0000_0000, 5'd25, 2'd1, 1'b0, 1'b1},
  '{op_load, size_word, 1'b0, 1'b0, 32'h0000_0108, 32'h0000_0000, 5'd26, 2'd1, 1'b0, 1'b1},
  '{op_store, size_byte, 1'b0, 1'b0, 32'h0000_0104, 32'h0000_0001, 5'd27, 2'd1, 1'b0, 1'b0},
  '{op_load, size_word, 1'b0, 1'b0, 32'h0000_0104, 32'h0000_0000, 5'd28, 2'd1, 1'b0, 1'b0}
};

// ==== sim/mem_stage_tb.sv ====
/*
 * testbench for the memory stage
 *   clock, reset and table-driven stimulus with xorshift data
 *   word model of local memory and queue of expected network requests
 *   network monitor comparing every transfer in order
 */

module mem_stage_tb;

  import mem_stage_pkg::*;

  localparam int dmem_words_lp = 1024;
  localparam int fifo_depth_lp = 2;
  localparam int timeout_lp    = 200;

  typedef struct packed {
    mem_op_e     op;
    mem_size_e   size;
    logic        uns;
    logic        miss;
    logic [31:0] rs1;
    logic [31:0] offset;
    logic [4:0]  rd;
    logic [1:0]  net;
    logic        probe;
    logic        exp_res;
  } row_s;

  `include "mem_stage_tb_table.svh"

  logic        clk_i;
  logic        reset_i;
  logic        exe_v_i;
  decode_s     exe_decode_i;
  logic [31:0] exe_rs1_i;
  logic [31:0] exe_rs2_i;
  logic [31:0] exe_offset_i;
  logic [4:0]  exe_rd_i;
  logic        icache_miss_i;
  logic [31:0] pc_plus4_i;
  logic        net_ready_i;
  logic        exe_ready_o;
  logic        load_v_o;
  logic [31:0] load_data_o;
  logic [4:0]  load_rd_o;
  logic        reserve_v_o;
  logic        net_v_o;
  remote_req_s net_req_o;

  logic [31:0] mem_model [dmem_words_lp];
  remote_req_s exp_q [$];
  logic [31:0] data_seed;
  logic [31:0] ready_seed;
  logic [1:0]  net_mode;

  mem_stage #(.dmem_words_p(dmem_words_lp), .fifo_depth_p(fifo_depth_lp)) UUT (.*);

  task automatic abort_run();
    $display("Some tests failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic report_mismatch(input string msg);
    $display("[FAIL] t=%0t %s", $time, msg);
    abort_run();
  endtask

  task automatic report_timeout(input string what);
    $display("timed out waiting for %s", what);
    abort_run();
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [3:0] byte_mask(input mem_size_e size, input logic [1:0] low);
    case (size)
      size_byte: return {low == 2'd3, low == 2'd2, low == 2'd1, low == 2'd0};
      size_half: return {{2{low[1]}}, {2{~low[1]}}};
      default:   return 4'b1111;
    endcase
  endfunction

  function automatic logic [31:0] lane_data(input mem_size_e size, input logic [31:0] rs2);
    case (size)
      size_byte: return {4{rs2[7:0]}};
      size_half: return {2{rs2[15:0]}};
      default:   return rs2;
    endcase
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] mask);
    logic [31:0] keep;
    keep = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
    return (old & ~keep) | (data & keep);
  endfunction

  function automatic logic [31:0] extend_load(input logic [31:0] word, input mem_size_e size,
                                              input logic uns, input logic [1:0] low);
    logic [31:0] lane;
    lane = word >> (8 * low);
    case (size)
      size_byte: return uns ? {24'h0, lane[7:0]} : {{24{lane[7]}}, lane[7:0]};
      size_half: return uns ? {16'h0, lane[15:0]} : {{16{lane[15]}}, lane[15:0]};
      default:   return word;
    endcase
  endfunction

  // advance one cycle and drive net_ready_i for the current mode
  task automatic next_cycle();
    @(posedge clk_i);
    #1;
    ready_seed = xorshift(ready_seed);
    case (net_mode)
      2'd0:    net_ready_i = 1'b0;
      2'd1:    net_ready_i = 1'b1;
      default: net_ready_i = ready_seed[0] | ready_seed[1];
    endcase
  endtask

  task automatic check_load(input logic exp_v, input logic [31:0] exp_data,
                            input logic [4:0] exp_rd);
    assert (load_v_o === exp_v)
      else report_mismatch($sformatf("load_v_o %b, expected %b", load_v_o, exp_v));
    if (exp_v) begin
      assert (load_data_o === exp_data)
        else report_mismatch($sformatf("load_data_o %h, expected %h", load_data_o, exp_data));
      assert (load_rd_o === exp_rd)
        else report_mismatch($sformatf("load_rd_o %0d, expected %0d", load_rd_o, exp_rd));
    end
  endtask

  task automatic apply_row(input row_s r);
    logic [31:0] addr;
    logic [31:0] rs2;
    logic [31:0] exp_data;
    logic        is_local;
    logic        rdy;
    remote_req_s req;
    int          waited;
    net_mode = r.net;
    waited = 0;
    // op_none rows idle until every expected request has left
    if (r.op == op_none) begin
      exe_v_i = 1'b0;
      while (exp_q.size() != 0) begin
        next_cycle();
        check_load(1'b0, '0, '0);
        waited++;
        if (waited > timeout_lp) report_timeout("the network queue to drain");
      end
      return;
    end
    data_seed = xorshift(data_seed);
    rs2 = data_seed;
    addr = r.rs1 + r.offset;
    is_local = ~r.miss & (addr[31:12] == 20'h0);
    exp_data = extend_load(mem_model[addr[11:2]], r.size, r.uns, addr[1:0]);
    exe_v_i = 1'b1;
    exe_decode_i = '{op: r.op, size: r.size, is_unsigned: r.uns};
    exe_rs1_i = r.rs1;
    exe_rs2_i = rs2;
    exe_offset_i = r.offset;
    exe_rd_i = r.rd;
    icache_miss_i = r.miss;
    pc_plus4_i = r.rs1;
    do begin
      @(negedge clk_i);
      rdy = exe_ready_o;
      if (r.probe) begin
        assert (rdy === 1'b0) else report_mismatch("exe_ready_o high with a full queue");
      end else if (is_local) begin
        assert (rdy === 1'b1) else report_mismatch("exe_ready_o low for a local item");
      end
      next_cycle();
      check_load(rdy & ~r.probe & is_local & (r.op != op_store), exp_data, r.rd);
      waited++;
      if (waited > timeout_lp) report_timeout("the execute handshake");
    end while (!rdy && !r.probe);
    exe_v_i = 1'b0;
    if (r.probe) return;
    if (is_local && r.op == op_store) begin
      mem_model[addr[11:2]] = merge_bytes(mem_model[addr[11:2]], lane_data(r.size, rs2),
                                          byte_mask(r.size, addr[1:0]));
    end else if (!is_local) begin
      // an instruction miss is a word read of the dram copy of the pc
      req.op = r.miss ? op_load : r.op;
      req.mask = r.miss ? 4'b1111 : byte_mask(r.size, addr[1:0]);
      req.load_info.icache_fetch = r.miss;
      req.load_info.is_unsigned = r.miss ? 1'b0 : r.uns;
      req.load_info.size = r.miss ? size_word : r.size;
      req.load_info.part_sel = r.miss ? 2'b00 : addr[1:0];
      req.reg_id = r.rd;
      req.data = lane_data(r.size, rs2);
      req.addr = r.miss ? ((r.rs1 - 32'd4) | 32'h8000_0000) : addr;
      exp_q.push_back(req);
    end
    assert (reserve_v_o === r.exp_res)
      else report_mismatch($sformatf("reserve_v_o %b, expected %b", reserve_v_o, r.exp_res));
  endtask

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // network side, transfers compared in acceptance order
  initial begin
    forever begin
      @(negedge clk_i);
      if (reset_i && net_v_o) begin
        assert (exp_q.size() != 0) else report_mismatch("net_v_o high with nothing expected");
        if (net_ready_i) begin
          assert (net_req_o === exp_q[0])
            else report_mismatch($sformatf("net_req_o %h, expected %h", net_req_o, exp_q[0]));
          void'(exp_q.pop_front());
        end
      end
    end
  end

  initial begin
    reset_i = 1'b0;
    exe_v_i = 1'b0;
    exe_decode_i = '0;
    exe_rs1_i = '0;
    exe_rs2_i = '0;
    exe_offset_i = '0;
    exe_rd_i = '0;
    icache_miss_i = 1'b0;
    pc_plus4_i = '0;
    net_ready_i = 1'b0;
    net_mode = 2'd0;
    data_seed = 32'd69810;
    ready_seed = 32'd69810;
    repeat (16) @(posedge clk_i);
    #1;
    assert (!load_v_o && !net_v_o && !reserve_v_o)
      else report_mismatch("outputs not idle after reset");
    reset_i = 1'b1;
    for (int i = 0; i < num_rows_lp; i++) begin
      apply_row(table_rows[i]);
    end
    $display("All tests passed");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+sim
logic/mem_stage_pkg.sv
logic/lsu.sv
logic/dmem.sv
logic/load_align.sv
logic/remote_req_fifo.sv
logic/mem_stage.sv
sim/mem_stage_tb.sv

// ==== Makefile ====
# Verilator build and run for the memory stage testbench

VERILATOR ?= verilator
TOP       ?= mem_stage_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All tests passed

SOURCES := $(wildcard logic/*.sv sim/*.sv sim/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
